/* dv/icache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
	parameter int SEED = 32'h3aee8b19
) (
	input logic clk,
	input logic reset,
	input logic mem_req,
	input logic [31:0] mem_read_addr,
	output logic [31:0] mem_read_data,
	output logic mem_addr_ok,
	output logic mem_data_ok
);

	integer seed = SEED;
	integer r;
	logic addr_ok_q = 1'b0;
	logic data_ok_q = 1'b0;
	logic [31:0] data_q = '0;
	// accepted word addresses, answered in order
	logic [31:0] pend_q [$];

	assign mem_addr_ok = addr_ok_q;
	assign mem_data_ok = data_ok_q;
	assign mem_read_data = data_q;

	// memory contents, every bit of the word address counts
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return {addr[15:2], addr[31:16], 2'b01} ^ 32'h5ca1ab1e;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			addr_ok_q <= 1'b0;
			data_ok_q <= 1'b0;
			pend_q.delete();
		end
		else
		begin
			// request taken by the cache at this edge
			if (mem_req && addr_ok_q)
				pend_q.push_back(mem_read_addr);
			// accept roughly two cycles in three
			addr_ok_q <= ($unsigned($random(seed)) % 3) != 0;
			r = $random(seed);
			// return about every other cycle while words are owed
			if (pend_q.size() != 0 && r[0])
			begin
				data_q <= word_at(pend_q.pop_front());
				data_ok_q <= 1'b1;
			end
			else
			begin
				data_ok_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* dv/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_tb;

	localparam int TIMEOUT = 400;
	localparam int NUM_READS = 300;

	logic clk;
	logic reset;
	logic cpu_req;
	logic [31:0] instr_addr;
	logic cpu_addr_ok;
	logic cpu_data_ok;
	logic [31:0] instr_rdata;
	logic mem_req;
	logic [31:0] mem_read_addr;
	logic [31:0] mem_read_data;
	logic mem_addr_ok;
	logic mem_data_ok;

	integer seed;
	int error_count;
	// reference cache, tags and valid bits per way and set, pointer per set
	logic [`CACHE_T-1:0] ref_tag [`CACHE_E][`SET_NUM];
	logic ref_valid [`CACHE_E][`SET_NUM];
	logic ref_ptr [`SET_NUM];
	// few tags so that sets conflict often
	logic [`CACHE_T-1:0] tag_pool [6];
	// memory requests accepted during the current read
	logic [31:0] req_q [$];
	int outstanding;
	logic hold_pending;
	logic [31:0] hold_addr;

	icache_top dut0 (
		.clk           (clk),
		.reset         (reset),
		.instr_addr    (instr_addr),
		.cpu_req       (cpu_req),
		.cpu_addr_ok   (cpu_addr_ok),
		.cpu_data_ok   (cpu_data_ok),
		.instr_rdata   (instr_rdata),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok)
	);

	icache_mem_model #(.SEED(32'h3aee8b19)) mem0 (
		.clk           (clk),
		.reset         (reset),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// word the memory holds at a byte address
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return {addr[15:2], addr[31:16], 2'b01} ^ 32'h5ca1ab1e;
	endfunction

	function automatic logic model_hit(input logic [31:0] addr);
		logic hit;
		hit = 1'b0;
		for (int w = 0; w < `CACHE_E; w++)
		begin
			if (ref_valid[w][addr[7:4]] && ref_tag[w][addr[7:4]] == addr[31:8])
				hit = 1'b1;
		end
		return hit;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			$display("Done: errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Done: errors found");
		$fatal(1, "stopped after timeout");
	endtask

	// memory side watcher, sampled mid-cycle where everything is settled
	always @(negedge clk)
	begin
		if (reset)
		begin
			outstanding = 0;
			hold_pending = 1'b0;
		end
		else
		begin
			// a request left waiting must still be there, same address
			if (hold_pending)
			begin
				check_value("mem_req", 32'(mem_req), 32'd1);
				check_value("mem_read_addr", mem_read_addr, hold_addr);
			end
			hold_pending = mem_req && !mem_addr_ok;
			hold_addr = mem_read_addr;
			if (mem_req && mem_addr_ok)
			begin
				req_q.push_back(mem_read_addr);
				outstanding++;
			end
			if (mem_data_ok)
				outstanding--;
			check_value("outstanding_over_max", 32'(outstanding > `MAX_OUTSTANDING), 32'd0);
		end
	end

	task automatic do_read(input logic [31:0] addr);
		logic hit;
		logic way;
		int cycles;
		hit = model_hit(addr);
		cycles = 0;
		@(posedge clk);
		req_q.delete();
		cpu_req <= 1'b1;
		instr_addr <= addr;
		@(negedge clk);
		while (!cpu_addr_ok)
		begin
			cycles++;
			if (cycles > TIMEOUT)
				report_timeout("cpu_addr_ok");
			@(negedge clk);
		end
		check_value("cpu_data_ok", 32'(cpu_data_ok), 32'd1);
		check_value("instr_rdata", instr_rdata, expected_word(addr));
		if (hit)
		begin
			// answered in the request cycle, memory untouched
			check_value("hit_cycles", 32'(cycles), 32'd0);
			check_value("mem_req", 32'(mem_req), 32'd0);
			check_value("hit_mem_requests", 32'(req_q.size()), 32'd0);
		end
		else
		begin
			check_value("miss_answered_at_once", 32'(cycles == 0), 32'd0);
			check_value("miss_mem_requests", 32'(req_q.size()), 32'(`LINE_WORDS));
			// words fetched from offset 0 upwards
			for (int i = 0; i < req_q.size(); i++)
				check_value("refill_addr", req_q[i], {addr[31:4], 4'h0} + 32'(4 * i));
			way = ref_ptr[addr[7:4]];
			ref_tag[way][addr[7:4]] = addr[31:8];
			ref_valid[way][addr[7:4]] = 1'b1;
			ref_ptr[addr[7:4]] = ~ref_ptr[addr[7:4]];
		end
		@(posedge clk);
		cpu_req <= 1'b0;
	endtask

	initial
	begin
		logic [31:0] addr;
		int k;
		seed = 32'h3aee8b19;
		error_count = 0;
		reset = 1'b1;
		cpu_req = 1'b0;
		instr_addr = '0;
		for (int s = 0; s < `SET_NUM; s++)
		begin
			ref_ptr[s] = 1'b0;
			for (int w = 0; w < `CACHE_E; w++)
				ref_valid[w][s] = 1'b0;
		end
		for (int t = 0; t < 6; t++)
			tag_pool[t] = 24'h004000 + 24'(t * 273);
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("mem_req", 32'(mem_req), 32'd0);
		check_value("cpu_addr_ok", 32'(cpu_addr_ok), 32'd0);
		check_value("cpu_data_ok", 32'(cpu_data_ok), 32'd0);
		// three tags in set 9, the third lands on the first one's way
		do_read(32'h0000_a190);
		do_read(32'h0000_b19c);
		do_read(32'h0000_c194);
		do_read(32'h0000_a198);
		do_read(32'h0000_b194);
		// random traffic over four sets
		for (int n = 0; n < NUM_READS; n++)
		begin
			k = $unsigned($random(seed)) % 6;
			addr[31:8] = tag_pool[k];
			addr[7:4] = 4'($unsigned($random(seed)) % 4);
			addr[3:2] = 2'($unsigned($random(seed)) % 4);
			addr[1:0] = 2'b00;
			do_read(addr);
			repeat ($unsigned($random(seed)) % 3) @(posedge clk);
		end
		repeat (2) @(posedge clk);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* icache.f */
+incdir+rtl
rtl/icache_addr_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_array_if.sv
rtl/icache_refill_if.sv
rtl/icache_way_array.sv
rtl/icache_replacement.sv
rtl/icache_refill_buffer.sv
rtl/icache_controller.sv
rtl/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

/* rtl/icache_addr_pkg.sv */
`default_nettype none
`include "icache_consts.svh"

package icache_addr_pkg;

	// upper address bits kept per line
	typedef logic [`CACHE_T-1:0] tag_t;

	// set select
	typedef logic [`CACHE_S-1:0] index_t;

	// word number inside a line
	// byte bits [1:0] are not part of it
	typedef logic [`CACHE_B-3:0] word_off_t;

	// one instruction word
	typedef logic [31:0] word_t;

	// whole line, packed
	// word 0 sits in bits [31:0], word 1 above it, and so on
	typedef logic [`LINE_WORDS*32-1:0] line_t;

	// way number, two ways so a single bit
	typedef logic way_t;

endpackage

`default_nettype wire

/* rtl/icache_array_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

interface icache_array_if
	import icache_addr_pkg::*;
();

	// lookup address, from the controller
	index_t index;
	tag_t tag;
	word_off_t offset;

	// line write, from the controller
	logic fill_en;
	way_t fill_way;
	line_t fill_line;

	// lookup result, from the way array
	logic hit;
	way_t hit_way;
	word_t rdata;

	modport array (
		input index, tag, offset, fill_en, fill_way, fill_line,
		output hit, hit_way, rdata
	);

	modport ctrl (
		output index, tag, offset, fill_en, fill_way, fill_line,
		input hit, hit_way, rdata
	);

endinterface

`default_nettype wire

/* rtl/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// address split, tag + index + byte offset = 32
`define CACHE_T 24
`define CACHE_S 4
`define CACHE_B 4

// sets addressed by the index field
`define SET_NUM (1 << `CACHE_S)

// associativity
`define CACHE_E 2

// 32-bit words in one line
`define LINE_WORDS 4

// word requests that may be unanswered during a refill
`define MAX_OUTSTANDING 4

`endif

/* rtl/icache_controller.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_controller
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic cpu_req,
	input logic [31:0] instr_addr,
	output logic cpu_addr_ok,
	output logic cpu_data_ok,
	output logic [31:0] instr_rdata,
	input way_t victim,
	icache_array_if.ctrl array,
	icache_refill_if.ctrl refill
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	refill_cmd_t cmd_q;
	way_t victim_q;
	logic [31:0] base_q;
	tag_t cur_tag;
	index_t cur_index;
	word_off_t cur_off;
	logic in_lookup;
	logic miss;

	// live address fields
	assign cur_tag = instr_addr[31 -: `CACHE_T];
	assign cur_index = instr_addr[`CACHE_B +: `CACHE_S];
	assign cur_off = instr_addr[`CACHE_B-1:2];

	// fill writes the line captured at miss time
	assign array.index = (state_q == FILL) ? base_q[`CACHE_B +: `CACHE_S] : cur_index;
	assign array.tag = (state_q == FILL) ? base_q[31 -: `CACHE_T] : cur_tag;
	assign array.offset = cur_off;
	assign array.fill_en = (state_q == FILL);
	assign array.fill_way = victim_q;
	assign array.fill_line = refill.line;

	assign refill.cmd = cmd_q;
	assign refill.base = base_q;

	// cpu is only answered from LOOKUP, hit gives address and data together
	assign in_lookup = (state_q == LOOKUP);
	assign miss = in_lookup && cpu_req && !array.hit;
	assign cpu_addr_ok = in_lookup && cpu_req && array.hit;
	assign cpu_data_ok = in_lookup && cpu_req && array.hit;
	assign instr_rdata = array.rdata;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			LOOKUP:
				if (miss)
					state_d = REFILL;
			REFILL:
				if (refill.done)
					state_d = FILL;
			// one cycle write, then the retried lookup hits
			FILL:
				state_d = LOOKUP;
			default:
				state_d = LOOKUP;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= LOOKUP;
			cmd_q <= NONE;
		end
		else
		begin
			state_q <= state_d;
			// START shows in the first REFILL cycle
			cmd_q <= miss ? START : NONE;
		end
	end

	// victim fixed at miss time, pointer may not move before the fill anyway
	always_ff @(posedge clk)
	begin
		if (miss)
		begin
			victim_q <= victim;
			base_q <= {instr_addr[31:`CACHE_B], {`CACHE_B{1'b0}}};
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_ctrl_pkg.sv */
`default_nettype none
`include "icache_consts.svh"

package icache_ctrl_pkg;

	// miss handling states
	// LOOKUP answers hits, REFILL waits for the line, FILL writes it
	typedef enum logic [1:0]
	{
		LOOKUP,
		REFILL,
		FILL
	} ctrl_state_t;

	// command to the refill buffer, START is a one cycle pulse
	typedef enum logic
	{
		NONE,
		START
	} refill_cmd_t;

endpackage

`default_nettype wire

/* rtl/icache_refill_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_refill_buffer
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	icache_refill_if.buffer refill,
	output logic mem_req,
	output logic [31:0] mem_read_addr,
	input logic [31:0] mem_read_data,
	input logic mem_addr_ok,
	input logic mem_data_ok
);

	// counters need one bit more than the index to reach the full count
	localparam int CNT_W = $clog2(`LINE_WORDS) + 1;
	localparam int OUT_W = $clog2(`MAX_OUTSTANDING) + 1;

	logic active_q;
	logic done_q;
	logic [CNT_W-1:0] issued_q;
	logic [CNT_W-1:0] returned_q;
	logic [OUT_W-1:0] pending_q;
	logic [31:0] base_q;
	line_t line_q;
	logic accept;
	logic ret;
	logic last;

	// request while words remain and the in-flight window has room
	// pending only drops while waiting, so mem_req holds until accepted
	assign mem_req = active_q && (issued_q < CNT_W'(`LINE_WORDS))
		&& (pending_q < OUT_W'(`MAX_OUTSTANDING));

	// word address follows the issue count, stays put until mem_addr_ok
	assign mem_read_addr = {base_q[31:`CACHE_B], word_off_t'(issued_q), 2'b00};

	assign accept = mem_req && mem_addr_ok;
	assign ret = active_q && mem_data_ok;
	assign last = ret && (returned_q == CNT_W'(`LINE_WORDS - 1));

	assign refill.done = done_q;
	assign refill.line = line_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active_q <= 1'b0;
			done_q <= 1'b0;
			issued_q <= '0;
			returned_q <= '0;
			pending_q <= '0;
		end
		else
		begin
			// done lines up with the cycle where the last word is in line_q
			done_q <= last;
			if (refill.cmd == START)
			begin
				active_q <= 1'b1;
				issued_q <= '0;
				returned_q <= '0;
				pending_q <= '0;
			end
			else
			begin
				if (accept)
					issued_q <= issued_q + 1'b1;
				if (ret)
					returned_q <= returned_q + 1'b1;
				// accept and return in the same cycle leave the count alone
				if (accept && !ret)
					pending_q <= pending_q + 1'b1;
				else if (!accept && ret)
					pending_q <= pending_q - 1'b1;
				if (last)
					active_q <= 1'b0;
			end
		end
	end

	// line base and gathered words
	// memory answers in order, so the return count is the word offset
	always_ff @(posedge clk)
	begin
		if (refill.cmd == START)
			base_q <= refill.base;
		if (ret)
			line_q[word_off_t'(returned_q)*32 +: 32] <= mem_read_data;
	end

endmodule

`default_nettype wire

/* rtl/icache_refill_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

interface icache_refill_if
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
();

	// request side, from the controller
	refill_cmd_t cmd;
	// byte address of word 0 of the missing line
	logic [31:0] base;

	// result side, from the refill buffer
	// done pulses once the last word has landed in line
	logic done;
	line_t line;

	modport buffer (
		input cmd, base,
		output done, line
	);

	modport ctrl (
		output cmd, base,
		input done, line
	);

endinterface

`default_nettype wire

/* rtl/icache_replacement.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_replacement
	import icache_addr_pkg::*;
(
	input logic clk,
	input logic reset,
	input index_t index,
	input logic fill_en,
	output way_t victim
);

	// one pointer bit per set, names the way to evict next
	logic [`SET_NUM-1:0] ptr_q;

	// victim for the set currently addressed
	assign victim = way_t'(ptr_q[index]);

	// round robin, every fill of a set moves its pointer to the other way
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr_q <= '0;
		end
		else if (fill_en)
		begin
			ptr_q[index] <= ~ptr_q[index];
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_top
	import icache_addr_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [31:0] instr_addr,
	input logic cpu_req,
	output logic cpu_addr_ok,
	output logic cpu_data_ok,
	output logic [31:0] instr_rdata,
	output logic mem_req,
	output logic [31:0] mem_read_addr,
	input logic [31:0] mem_read_data,
	input logic mem_addr_ok,
	input logic mem_data_ok
);

	// controller to way array
	icache_array_if array_bus ();
	// controller to refill buffer
	icache_refill_if refill_bus ();

	way_t victim;

	icache_controller u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.instr_addr  (instr_addr),
		.cpu_addr_ok (cpu_addr_ok),
		.cpu_data_ok (cpu_data_ok),
		.instr_rdata (instr_rdata),
		.victim      (victim),
		.array       (array_bus.ctrl),
		.refill      (refill_bus.ctrl)
	);

	icache_way_array u_ways (
		.clk   (clk),
		.reset (reset),
		.array (array_bus.array)
	);

	// pointer follows the array's index and write strobe
	icache_replacement u_repl (
		.clk     (clk),
		.reset   (reset),
		.index   (array_bus.index),
		.fill_en (array_bus.fill_en),
		.victim  (victim)
	);

	icache_refill_buffer u_refill (
		.clk           (clk),
		.reset         (reset),
		.refill        (refill_bus.buffer),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok)
	);

endmodule

`default_nettype wire

/* rtl/icache_way_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_consts.svh"

module icache_way_array
	import icache_addr_pkg::*;
(
	input logic clk,
	input logic reset,
	icache_array_if.array array
);

	// storage, first index is the way, second the set
	logic [`SET_NUM-1:0] valid_q [`CACHE_E];
	tag_t tag_q [`CACHE_E][`SET_NUM];
	line_t line_q [`CACHE_E][`SET_NUM];

	logic [`CACHE_E-1:0] way_hit;
	way_t hit_way_w;
	line_t hit_line;

	// tag compare in every way at once
	always_comb
	begin
		for (int w = 0; w < `CACHE_E; w++)
		begin
			way_hit[w] = valid_q[w][array.index] && (tag_q[w][array.index] == array.tag);
		end
	end

	// one-hot hit vector to way number
	// at most one way can match since a line is only filled on a miss
	always_comb
	begin
		hit_way_w = '0;
		for (int w = 0; w < `CACHE_E; w++)
		begin
			if (way_hit[w])
				hit_way_w = way_t'(w);
		end
	end

	assign array.hit = |way_hit;
	assign array.hit_way = hit_way_w;

	// addressed word out of the matching line
	assign hit_line = line_q[hit_way_w][array.index];
	assign array.rdata = hit_line[array.offset*32 +: 32];

	// valid bits, all lines empty after reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int w = 0; w < `CACHE_E; w++)
				valid_q[w] <= '0;
		end
		else if (array.fill_en)
		begin
			valid_q[array.fill_way][array.index] <= 1'b1;
		end
	end

	// tag and data written together with the valid bit
	always_ff @(posedge clk)
	begin
		if (array.fill_en)
		begin
			tag_q[array.fill_way][array.index] <= array.tag;
			line_q[array.fill_way][array.index] <= array.fill_line;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the icache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f icache.f --top-module icache_tb -Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/icache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the run passes only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -q "^Done: no errors$"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
